// File: mac_avst_pkg.sv
// MAC-side Avalon-ST beat types and PTP timestamp types
// shared by the transmit slice, the receive adapter and the timestamp report

package mac_avst_pkg;

    localparam int AVST_DATA_W = 64;             // beat data width toward the MAC
    localparam int AVST_BYTES  = AVST_DATA_W / 8;
    localparam int PTP_TS_W    = 96;             // 48b seconds, 32b ns, 16b fractional ns
    localparam int PTP_TAG_W   = 8;
    localparam int EMPTY_W     = 3;              // counts unused bytes on the eop beat

    typedef logic [PTP_TS_W-1:0]  ptp_ts_t;
    typedef logic [PTP_TAG_W-1:0] ptp_tag_t;

    typedef struct packed {
        logic [AVST_DATA_W-1:0] data;            // first wire byte in msb when reversed
        logic                   sop;
        logic                   eop;
        logic [EMPTY_W-1:0]     empty;
        logic                   error;
    } avst_beat_t;

    typedef struct packed {
        logic [AVST_DATA_W-1:0] data;
        logic                   sop;
        logic                   eop;
        logic [EMPTY_W-1:0]     empty;
        logic [5:0]             error;           // per-cause error flags from the MAC
    } avst_rx_beat_t;

    typedef struct packed {
        ptp_ts_t  ts;
        ptp_tag_t tag;
    } tx_ts_report_t;

    // mirror byte order between stream and MAC lane order
    function automatic logic [AVST_DATA_W-1:0] reverse_bytes(input logic [AVST_DATA_W-1:0] d);
        logic [AVST_DATA_W-1:0] r;
        for (int i = 0; i < AVST_BYTES; i++) begin
            r[8*i +: 8] = d[8*(AVST_BYTES-1-i) +: 8];
        end
        return r;
    endfunction

endpackage

// File: mac_stream_pkg.sv
// user-side frame stream types, AXI-Stream style
// byte 0 of tdata is the first byte on the wire, tkeep is contiguous from bit 0

package mac_stream_pkg;

    import mac_avst_pkg::*;

    localparam int DATA_W     = AVST_DATA_W;     // same beat width on both sides
    localparam int DATA_BYTES = DATA_W / 8;

    typedef struct packed {
        logic [DATA_W-1:0]     tdata;
        logic [DATA_BYTES-1:0] tkeep;
        logic                  tlast;
    } stream_beat_t;

    typedef struct packed {
        ptp_tag_t ptp_tag;                       // echoed back in the tx timestamp report
        logic     err;                           // ask the MAC to corrupt the frame
    } tx_user_t;

    typedef struct packed {
        ptp_ts_t ptp_ts;                         // ingress time captured at sop
        logic    err;                            // MAC flagged the frame bad
    } rx_user_t;

endpackage

// File: mac_tx_adapter.sv
// transmit adapter, frame stream to Avalon-ST beats
// marks sop/eop, derives empty from tkeep and holds each beat plus PTP tag
// in a one-deep output register slice that drives the MAC directly

`timescale 1ns/10ps

module mac_tx_adapter
    import mac_stream_pkg::*, mac_avst_pkg::*;
#(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic         mac_clk,
    input  logic         mac_rst,

    input  stream_beat_t i_tx_beat,
    input  tx_user_t     i_tx_user,
    input  logic         i_tx_valid,
    output logic         o_tx_ready,

    output avst_beat_t   o_mac_tx_beat,
    output ptp_tag_t     o_mac_tx_tag,
    output logic         o_mac_tx_valid,
    input  logic         i_mac_tx_ready
);

    // unused byte count on the last beat
    function automatic logic [EMPTY_W-1:0] keep_to_empty(input logic [DATA_BYTES-1:0] keep);
        logic [EMPTY_W:0] ones;
        ones = '0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            ones = ones + (EMPTY_W+1)'(keep[i]);
        end
        return EMPTY_W'(DATA_BYTES - ones);
    endfunction

    logic       sop_pending;                     // next accepted beat opens a frame
    logic       slice_ready;
    logic       tx_fire;
    avst_beat_t next_beat;

    avst_beat_t beat_q;
    ptp_tag_t   tag_q;
    logic       valid_q;

    // slice takes a new beat when empty or when the MAC drains it this cycle
    assign slice_ready = i_mac_tx_ready || !valid_q;
    assign o_tx_ready  = slice_ready;
    assign tx_fire     = i_tx_valid && slice_ready;

    always_ff @(posedge mac_clk) begin
        if (mac_rst) begin
            sop_pending <= 1'b1;
        end else if (tx_fire) begin
            sop_pending <= i_tx_beat.tlast;      // reopen after end of frame
        end
    end

    always_comb begin
        next_beat.data  = BYTE_REVERSE ? reverse_bytes(i_tx_beat.tdata) : i_tx_beat.tdata;
        next_beat.sop   = sop_pending;
        next_beat.eop   = i_tx_beat.tlast;
        next_beat.empty = i_tx_beat.tlast ? keep_to_empty(i_tx_beat.tkeep) : '0;
        next_beat.error = i_tx_beat.tlast && i_tx_user.err;  // only meaningful at eop
    end

    always_ff @(posedge mac_clk) begin
        if (mac_rst) begin
            valid_q <= 1'b0;
        end else if (slice_ready) begin
            valid_q <= i_tx_valid;
        end
    end

    always_ff @(posedge mac_clk) begin
        if (slice_ready) begin
            beat_q <= next_beat;
            tag_q  <= i_tx_user.ptp_tag;         // tag travels with its beat
        end
    end

    // MAC inputs come straight from the slice registers
    assign o_mac_tx_beat  = beat_q;
    assign o_mac_tx_tag   = tag_q;
    assign o_mac_tx_valid = valid_q;

endmodule

// File: mac_rx_adapter.sv
// receive adapter, Avalon-ST beats to frame stream beats
// combinational: rebuilds tkeep from empty, restores byte order,
// folds the MAC error vector to one bit and forwards sop

`timescale 1ns/10ps

module mac_rx_adapter
    import mac_stream_pkg::*, mac_avst_pkg::*;
#(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  avst_rx_beat_t i_mac_rx_beat,
    input  logic          i_mac_rx_valid,

    output stream_beat_t  o_beat,
    output logic          o_sop,
    output logic          o_err,
    output logic          o_valid
);

    localparam logic [DATA_BYTES-1:0] KEEP_ALL = '1;

    logic [DATA_W-1:0]     data_ord;
    logic [DATA_BYTES-1:0] keep;

    assign data_ord = BYTE_REVERSE ? reverse_bytes(i_mac_rx_beat.data) : i_mac_rx_beat.data;

    // lowest DATA_BYTES-empty bytes valid at eop, all bytes otherwise
    assign keep = i_mac_rx_beat.eop ? (KEEP_ALL >> i_mac_rx_beat.empty) : KEEP_ALL;

    always_comb begin
        o_beat.tdata = data_ord;
        o_beat.tkeep = keep;
        o_beat.tlast = i_mac_rx_beat.eop;
    end

    assign o_sop   = i_mac_rx_beat.sop;          // next stage latches the timestamp here
    assign o_err   = |i_mac_rx_beat.error;       // any cause marks the frame bad
    assign o_valid = i_mac_rx_valid;

endmodule

// File: mac_rx_ts_insert.sv
// receive timestamp insertion
// latches the ingress timestamp on sop and attaches it to every beat of the frame,
// with one register stage on beat, user and valid

`timescale 1ns/10ps

module mac_rx_ts_insert
    import mac_stream_pkg::*, mac_avst_pkg::*;
(
    input  logic         mac_clk,
    input  logic         mac_rst,

    input  stream_beat_t i_beat,
    input  logic         i_sop,
    input  logic         i_err,
    input  logic         i_valid,
    input  ptp_ts_t      i_ts,

    output stream_beat_t o_rx_beat,
    output rx_user_t     o_rx_user,
    output logic         o_rx_valid
);

    ptp_ts_t      ts_hold;                       // timestamp of the frame in flight
    ptp_ts_t      ts_sel;
    logic         sop_fire;

    stream_beat_t beat_q;
    rx_user_t     user_q;
    logic         valid_q;

    assign sop_fire = i_valid && i_sop;

    // sop beat takes the live value, later beats reuse the held one
    assign ts_sel = sop_fire ? i_ts : ts_hold;

    always_ff @(posedge mac_clk) begin
        if (sop_fire) begin
            ts_hold <= i_ts;
        end
    end

    always_ff @(posedge mac_clk) begin
        if (mac_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;                  // no back-pressure on receive
        end
    end

    always_ff @(posedge mac_clk) begin
        if (i_valid) begin
            beat_q <= i_beat;
            user_q <= '{ptp_ts: ts_sel, err: i_err};
        end
    end

    assign o_rx_beat  = beat_q;
    assign o_rx_user  = user_q;
    assign o_rx_valid = valid_q;

endmodule

// File: eth_mac_datapath.sv
// Ethernet MAC wrapper packet datapath, mac_clk domain
// transmit frames to Avalon-ST through a register slice, receive beats back
// to frames with ingress timestamps, and the tx timestamp report passed through

`timescale 1ns/10ps

module eth_mac_datapath
    import mac_stream_pkg::*, mac_avst_pkg::*;
#(
    parameter bit BYTE_REVERSE = 1'b1
) (
    input  logic          mac_clk,
    input  logic          mac_rst,

    // user transmit stream
    input  stream_beat_t  i_tx_beat,
    input  tx_user_t      i_tx_user,
    input  logic          i_tx_valid,
    output logic          o_tx_ready,

    // MAC transmit side
    output avst_beat_t    o_mac_tx_beat,
    output ptp_tag_t      o_mac_tx_tag,
    output logic          o_mac_tx_valid,
    input  logic          i_mac_tx_ready,

    // MAC receive side
    input  avst_rx_beat_t i_mac_rx_beat,
    input  logic          i_mac_rx_valid,
    input  ptp_ts_t       i_mac_rx_its,

    // user receive stream
    output stream_beat_t  o_rx_beat,
    output rx_user_t      o_rx_user,
    output logic          o_rx_valid,

    // transmit timestamp report
    input  tx_ts_report_t i_mac_tx_ts,
    input  logic          i_mac_tx_ts_valid,
    output tx_ts_report_t o_tx_ts,
    output logic          o_tx_ts_valid
);

    stream_beat_t rx_beat_int;
    logic         rx_sop_int;
    logic         rx_err_int;
    logic         rx_valid_int;

    mac_tx_adapter #(
        .BYTE_REVERSE   (BYTE_REVERSE)
    ) u_tx_adapter (
        .mac_clk        (mac_clk),
        .mac_rst        (mac_rst),
        .i_tx_beat      (i_tx_beat),
        .i_tx_user      (i_tx_user),
        .i_tx_valid     (i_tx_valid),
        .o_tx_ready     (o_tx_ready),
        .o_mac_tx_beat  (o_mac_tx_beat),
        .o_mac_tx_tag   (o_mac_tx_tag),
        .o_mac_tx_valid (o_mac_tx_valid),
        .i_mac_tx_ready (i_mac_tx_ready)
    );

    mac_rx_adapter #(
        .BYTE_REVERSE   (BYTE_REVERSE)
    ) u_rx_adapter (
        .i_mac_rx_beat  (i_mac_rx_beat),
        .i_mac_rx_valid (i_mac_rx_valid),
        .o_beat         (rx_beat_int),
        .o_sop          (rx_sop_int),
        .o_err          (rx_err_int),
        .o_valid        (rx_valid_int)
    );

    mac_rx_ts_insert u_rx_ts_insert (
        .mac_clk        (mac_clk),
        .mac_rst        (mac_rst),
        .i_beat         (rx_beat_int),
        .i_sop          (rx_sop_int),
        .i_err          (rx_err_int),
        .i_valid        (rx_valid_int),
        .i_ts           (i_mac_rx_its),
        .o_rx_beat      (o_rx_beat),
        .o_rx_user      (o_rx_user),
        .o_rx_valid     (o_rx_valid)
    );

    // report goes out the same cycle, nothing can stall it
    assign o_tx_ts       = i_mac_tx_ts;
    assign o_tx_ts_valid = i_mac_tx_ts_valid;

endmodule

// File: eth_mac_datapath_tb_tasks.svh
// directed tests and typed compare tasks for the MAC datapath testbench

// user byte k lands in MAC byte 7-k
function automatic logic [DATA_W-1:0] swap_lanes(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    for (int k = 0; k < DATA_BYTES; k++) begin
        r[8*(DATA_BYTES-1-k) +: 8] = d[8*k +: 8];
    end
    return r;
endfunction

function automatic avst_beat_t tx_expect(input stream_beat_t b, input tx_user_t u, input bit sop);
    avst_beat_t e;
    int         used;
    used = 0;
    for (int k = 0; k < DATA_BYTES; k++) begin
        if (b.tkeep[k]) used++;
    end
    e.data  = swap_lanes(b.tdata);
    e.sop   = sop;
    e.eop   = b.tlast;
    e.empty = b.tlast ? EMPTY_W'(DATA_BYTES - used) : '0;
    e.error = b.tlast && u.err;
    return e;
endfunction

function automatic stream_beat_t make_tx_beat(input bit last, input int nbytes);
    stream_beat_t b;
    b.tdata = {$urandom, $urandom};
    b.tkeep = last ? DATA_BYTES'((1 << nbytes) - 1) : '1;
    b.tlast = last;
    return b;
endfunction

function automatic tx_user_t make_tx_user(input bit err);
    tx_user_t u;
    u.ptp_tag = 8'($urandom);
    u.err     = err;
    return u;
endfunction

task automatic check_avst_beat(input string what, input avst_beat_t got, input ptp_tag_t got_tag,
                               input avst_beat_t exp, input ptp_tag_t exp_tag);
    if (got !== exp || got_tag !== exp_tag) begin
        err_count++;
        $display("Error @ %0t: %s got %h tag %h, expected %h tag %h",
                 $time, what, got, got_tag, exp, exp_tag);
    end
endtask

task automatic check_rx_beat(input string what, input stream_beat_t got, input rx_user_t got_u,
                             input stream_beat_t exp, input rx_user_t exp_u);
    if (got !== exp || got_u !== exp_u) begin
        err_count++;
        $display("Error @ %0t: %s got %h user %h, expected %h user %h",
                 $time, what, got, got_u, exp, exp_u);
    end
endtask

task automatic check_ts_report(input string what, input tx_ts_report_t got,
                               input tx_ts_report_t exp);
    if (got !== exp) begin
        err_count++;
        $display("Error @ %0t: %s got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_valids_low();
    @(negedge mac_clk);
    if (o_mac_tx_valid !== 1'b0 || o_rx_valid !== 1'b0) begin
        err_count++;
        $display("Error @ %0t: valid outputs not low after reset", $time);
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
        tests_failed++;
        $display("test %s: %0d errors", name, err_count - errs_before);
    end else begin
        $display("test %s: ok", name);
    end
endtask

task automatic apply_reset();
    mac_rst <= 1'b1;
    repeat (2) @(posedge mac_clk);
    mac_rst <= 1'b0;
    exp_sop = 1'b1;
endtask

// called on a rising edge and returns on the edge that takes the beat
task automatic send_tx_beat(input stream_beat_t b, input tx_user_t u);
    i_tx_beat  <= b;
    i_tx_user  <= u;
    i_tx_valid <= 1'b1;
    @(negedge mac_clk);
    while (!o_tx_ready) begin
        @(negedge mac_clk);
    end
    exp_beat.push_back(tx_expect(b, u, exp_sop));
    exp_tag.push_back(u.ptp_tag);
    acc_cyc.push_back(cycle);
    exp_sop = b.tlast;
    @(posedge mac_clk);
endtask

task automatic compare_tx_captures(input bit check_latency);
    while (cap_beat.size() < exp_beat.size()) begin
        @(negedge mac_clk);
    end
    repeat (2) @(negedge mac_clk);          // room for a stray extra beat
    if (cap_beat.size() != exp_beat.size()) begin
        err_count++;
        $display("MAC took %0d beats but %0d were sent", cap_beat.size(), exp_beat.size());
    end
    for (int n = 0; n < exp_beat.size() && n < cap_beat.size(); n++) begin
        check_avst_beat($sformatf("tx beat %0d", n), cap_beat[n], cap_tag[n],
                        exp_beat[n], exp_tag[n]);
        if (check_latency && cap_cyc[n] != acc_cyc[n] + 1) begin
            err_count++;
            $display("Error @ %0t: tx beat %0d reached the MAC %0d cycles after acceptance",
                     $time, n, cap_cyc[n] - acc_cyc[n]);
        end
    end
    cap_beat.delete();
    cap_tag.delete();
    cap_cyc.delete();
    exp_beat.delete();
    exp_tag.delete();
    acc_cyc.delete();
endtask

// one frame of back-to-back MAC beats with a new timestamp input on every beat
task automatic drive_rx_frame(input int nbeats, input int empty, input logic [5:0] errv);
    avst_rx_beat_t b;
    stream_beat_t  e;
    rx_user_t      u;
    ptp_ts_t       its;
    ptp_ts_t       frame_ts;
    for (int n = 0; n < nbeats; n++) begin
        b.data  = {$urandom, $urandom};
        b.sop   = (n == 0);
        b.eop   = (n == nbeats - 1);
        b.empty = b.eop ? EMPTY_W'(empty) : '0;
        b.error = b.eop ? errv : '0;
        its     = {$urandom, $urandom, $urandom};
        if (b.sop) frame_ts = its;
        i_mac_rx_beat  <= b;
        i_mac_rx_its   <= its;
        i_mac_rx_valid <= 1'b1;
        e.tdata = swap_lanes(b.data);
        for (int k = 0; k < DATA_BYTES; k++) begin
            e.tkeep[k] = !b.eop || (k < DATA_BYTES - empty);
        end
        e.tlast  = b.eop;
        u.ptp_ts = frame_ts;
        u.err    = b.eop && (errv != 0);
        @(negedge mac_clk);
        rx_exp_beat.push_back(e);
        rx_exp_user.push_back(u);
        rx_exp_cyc.push_back(cycle + 1);
        @(posedge mac_clk);
    end
endtask

task automatic finish_rx();
    i_mac_rx_valid <= 1'b0;
    repeat (3) @(negedge mac_clk);
    if (rx_exp_beat.size() != 0) begin
        err_count++;
        $display("%0d receive beats never came out of the DUT", rx_exp_beat.size());
    end
    rx_exp_beat.delete();
    rx_exp_user.delete();
    rx_exp_cyc.delete();
endtask

task automatic reset_state_test();
    int errs;
    errs = err_count;
    check_valids_low();
    @(posedge mac_clk);
    send_tx_beat(make_tx_beat(1'b0, DATA_BYTES), make_tx_user(1'b0));  // frame left open
    i_mac_rx_valid <= 1'b1;                 // both valid inputs stay high into reset
    apply_reset();
    i_tx_valid     <= 1'b0;
    i_mac_rx_valid <= 1'b0;
    check_valids_low();
    compare_tx_captures(1'b1);
    @(posedge mac_clk);
    send_tx_beat(make_tx_beat(1'b1, 3), make_tx_user(1'b0));           // sop again after reset
    i_tx_valid <= 1'b0;
    compare_tx_captures(1'b1);
    report_test("reset_state", errs);
endtask

task automatic tx_conversion_test();
    int errs;
    errs = err_count;
    @(posedge mac_clk);
    send_tx_beat(make_tx_beat(1'b1, 5), make_tx_user(1'b1));
    send_tx_beat(make_tx_beat(1'b0, DATA_BYTES), make_tx_user(1'b1));  // err held off until eop
    send_tx_beat(make_tx_beat(1'b0, DATA_BYTES), make_tx_user(1'b0));
    send_tx_beat(make_tx_beat(1'b1, 2), make_tx_user(1'b1));
    i_tx_valid <= 1'b0;
    compare_tx_captures(1'b1);
    report_test("tx_conversion", errs);
endtask

task automatic tx_backpressure_test();
    int errs;
    bit last;
    errs = err_count;
    @(posedge mac_clk);
    rand_ready <= 1'b1;
    for (int n = 0; n < 40; n++) begin
        last = (n == 39) || ($urandom % 4 == 0);
        send_tx_beat(make_tx_beat(last, 1 + $urandom % DATA_BYTES),
                     make_tx_user(1'($urandom % 2)));
    end
    i_tx_valid <= 1'b0;
    rand_ready <= 1'b0;
    compare_tx_captures(1'b0);
    report_test("tx_backpressure", errs);
endtask

task automatic rx_conversion_test();
    int errs;
    errs = err_count;
    @(posedge mac_clk);
    drive_rx_frame(1, 0, 6'h00);
    drive_rx_frame(2, 3, 6'h00);
    drive_rx_frame(3, 7, 6'h21);
    drive_rx_frame(1, 5, 6'h01);
    drive_rx_frame(2, 1, 6'h00);
    finish_rx();
    report_test("rx_conversion", errs);
endtask

task automatic rx_timestamp_test();
    int errs;
    errs = err_count;
    @(posedge mac_clk);
    for (int f = 0; f < 6; f++) begin
        drive_rx_frame(1 + $urandom % 5, $urandom % DATA_BYTES, 6'h00);
    end
    finish_rx();
    report_test("rx_timestamp", errs);
endtask

task automatic ts_report_test();
    int            errs;
    tx_ts_report_t rep;
    errs = err_count;
    @(posedge mac_clk);
    for (int n = 0; n < 6; n++) begin
        rep.ts  = {$urandom, $urandom, $urandom};
        rep.tag = 8'($urandom);
        i_mac_tx_ts       <= rep;
        i_mac_tx_ts_valid <= 1'b1;
        @(negedge mac_clk);
        check_ts_report("ts report", o_tx_ts, rep);
        if (o_tx_ts_valid !== 1'b1) begin
            err_count++;
            $display("Error @ %0t: o_tx_ts_valid low while a report is driven", $time);
        end
        @(posedge mac_clk);
        i_mac_tx_ts_valid <= 1'b0;          // idle cycle between reports
        @(negedge mac_clk);
        if (o_tx_ts_valid !== 1'b0) begin
            err_count++;
            $display("Error @ %0t: o_tx_ts_valid high with no report driven", $time);
        end
        @(posedge mac_clk);
    end
    report_test("ts_report", errs);
endtask

// File: eth_mac_datapath_tb.sv
// testbench for the Ethernet MAC datapath
// plays the MAC on transmit and receive and runs the directed tests

`timescale 1ns/10ps

module eth_mac_datapath_tb
    import mac_stream_pkg::*, mac_avst_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int WATCHDOG_CYCLES = 2000;  // all tests together need well under this

    logic          mac_clk;
    logic          mac_rst;
    stream_beat_t  i_tx_beat;
    tx_user_t      i_tx_user;
    logic          i_tx_valid;
    logic          o_tx_ready;
    avst_beat_t    o_mac_tx_beat;
    ptp_tag_t      o_mac_tx_tag;
    logic          o_mac_tx_valid;
    logic          i_mac_tx_ready = 1'b1;
    avst_rx_beat_t i_mac_rx_beat;
    logic          i_mac_rx_valid;
    ptp_ts_t       i_mac_rx_its;
    stream_beat_t  o_rx_beat;
    rx_user_t      o_rx_user;
    logic          o_rx_valid;
    tx_ts_report_t i_mac_tx_ts;
    logic          i_mac_tx_ts_valid;
    tx_ts_report_t o_tx_ts;
    logic          o_tx_ts_valid;

    int cycle = 0;                          // rising edges seen so far
    int err_count;
    int tests_run;
    int tests_failed;
    bit rand_ready;                         // MAC model throttles tx ready
    bit exp_sop;                            // next accepted tx beat opens a frame
    bit slice_full;                         // tx output slice holds a beat

    avst_beat_t   cap_beat[$];              // beats the MAC took
    ptp_tag_t     cap_tag[$];
    int           cap_cyc[$];
    avst_beat_t   exp_beat[$];              // what the MAC should have taken
    ptp_tag_t     exp_tag[$];
    int           acc_cyc[$];               // cycle each user beat was accepted
    stream_beat_t rx_exp_beat[$];
    rx_user_t     rx_exp_user[$];
    int           rx_exp_cyc[$];

    eth_mac_datapath #(
        .BYTE_REVERSE (1'b1)
    ) u_dut (.*);

    always #(CLK_PERIOD/2) mac_clk = ~mac_clk;

    always @(posedge mac_clk) begin
        cycle          <= cycle + 1;
        i_mac_tx_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
    end

    // MAC model takes a beat on the next edge when valid and ready are high here
    always @(negedge mac_clk) begin
        if (o_mac_tx_valid && i_mac_tx_ready) begin
            cap_beat.push_back(o_mac_tx_beat);
            cap_tag.push_back(o_mac_tx_tag);
            cap_cyc.push_back(cycle);
        end
    end

    // one-deep slice model that predicts tx ready and MAC valid
    always @(negedge mac_clk) begin
        if (o_tx_ready !== (!slice_full || i_mac_tx_ready) ||
            o_mac_tx_valid !== slice_full) begin
            err_count++;
            $display("Error @ %0t: tx ready %b and MAC valid %b, slice model full %b",
                     $time, o_tx_ready, o_mac_tx_valid, slice_full);
        end
        if (mac_rst) begin
            slice_full = 1'b0;
        end else if (i_tx_valid && (!slice_full || i_mac_tx_ready)) begin
            slice_full = 1'b1;
        end else if (i_mac_tx_ready) begin
            slice_full = 1'b0;
        end
    end

    // receive outputs checked one cycle after each MAC beat
    always @(negedge mac_clk) begin
        if (o_rx_valid) begin
            if (rx_exp_beat.size() == 0) begin
                err_count++;
                $display("receive output gave a beat at %0t that was never driven", $time);
            end else begin
                if (rx_exp_cyc[0] != cycle) begin
                    err_count++;
                    $display("Error @ %0t: rx beat at cycle %0d, expected cycle %0d",
                             $time, cycle, rx_exp_cyc[0]);
                end
                check_rx_beat("rx beat", o_rx_beat, o_rx_user, rx_exp_beat[0], rx_exp_user[0]);
                void'(rx_exp_beat.pop_front());
                void'(rx_exp_user.pop_front());
                void'(rx_exp_cyc.pop_front());
            end
        end
    end

    `include "eth_mac_datapath_tb_tasks.svh"

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(77));
        mac_clk           = 1'b0;
        mac_rst           = 1'b1;
        i_tx_beat         = '0;
        i_tx_user         = '0;
        i_tx_valid        = 1'b0;
        i_mac_rx_beat     = '0;
        i_mac_rx_valid    = 1'b0;
        i_mac_rx_its      = '0;
        i_mac_tx_ts       = '0;
        i_mac_tx_ts_valid = 1'b0;
        err_count         = 0;
        tests_run         = 0;
        tests_failed      = 0;
        rand_ready        = 1'b0;
        exp_sop           = 1'b1;
        repeat (2) @(posedge mac_clk);
        mac_rst <= 1'b0;

        reset_state_test();
        tx_conversion_test();
        tx_backpressure_test();
        rx_conversion_test();
        rx_timestamp_test();
        ts_report_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: eth_mac_datapath.f
+incdir+.
mac_avst_pkg.sv
mac_stream_pkg.sv
mac_tx_adapter.sv
mac_rx_adapter.sv
mac_rx_ts_insert.sv
eth_mac_datapath.sv
eth_mac_datapath_tb.sv

// File: Makefile
# Verilator build and run for the MAC datapath testbench

VERILATOR ?= verilator
TOP       ?= eth_mac_datapath_tb
FILELIST  ?= eth_mac_datapath.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx 'PASS: all tests' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
